// File: hdl/cpu_isa_pkg.sv
// Instruction set definitions
`default_nettype none

package cpu_isa_pkg;

    typedef logic [15:0] word_t;    // Data, address and instruction word
    typedef logic [3:0]  reg_idx_t; // Register index

    // Opcode field encodings
    typedef enum logic [3:0] {
        OP_ADD  = 4'h0, // rd = rs + rt
        OP_SUB  = 4'h1, // rd = rs - rt
        OP_AND  = 4'h2,
        OP_XOR  = 4'h3,
        OP_ADDI = 4'h4, // rd = rs + sext(imm4)
        OP_LLB  = 4'h5, // rd = sext(low byte)
        OP_LW   = 4'h6, // rd = mem[rs + 2*imm4]
        OP_SW   = 4'h7, // mem[rs + 2*imm4] = rd
        OP_CALL = 4'h8, // Push pc + 2, sp -= 2
        OP_RET  = 4'h9, // Pop return address, sp += 2
        OP_HLT  = 4'hA,
        OP_NOP  = 4'hF
    } opcode_t;

    ////////////////////////////////////////////////////////////////////////////
    // Instruction field positions
    ////////////////////////////////////////////////////////////////////////////
    localparam int OPC_MSB = 15;
    localparam int OPC_LSB = 12;
    localparam int RD_MSB  = 11;
    localparam int RD_LSB  = 8;
    localparam int RS_MSB  = 7;
    localparam int RS_LSB  = 4;
    localparam int RT_MSB  = 3; // Also the 4-bit immediate
    localparam int RT_LSB  = 0;

    // Stack pointer lives in the top register
    localparam reg_idx_t SP_REG = 4'd15;

endpackage

`default_nettype wire

// File: hdl/cpu_ctrl_pkg.sv
// Pipeline control encodings
`default_nettype none

package cpu_ctrl_pkg;

    // ALU function, chosen in decode and applied in execute
    typedef enum logic [2:0] {
        ALU_ADD    = 3'd0,
        ALU_SUB    = 3'd1,
        ALU_AND    = 3'd2,
        ALU_XOR    = 3'd3,
        ALU_PASS_B = 3'd4  // Immediate straight through
    } alu_op_t;

    // Memory stage action
    typedef enum logic [2:0] {
        MEM_NONE  = 3'd0,
        MEM_LOAD  = 3'd1,
        MEM_STORE = 3'd2,
        MEM_CALL  = 3'd3, // Push return point, sp - 2
        MEM_RET   = 3'd4  // Pop return point, sp + 2
    } mem_op_t;

endpackage

`default_nettype wire

// File: hdl/reg_file.sv
// Sixteen entry register file
`timescale 1ns/1ns
`default_nettype none

module reg_file (
    input  logic                  clk,
    input  logic                  rst,
    input  cpu_isa_pkg::reg_idx_t raddr_a,
    input  cpu_isa_pkg::reg_idx_t raddr_b,
    output cpu_isa_pkg::word_t    rdata_a,
    output cpu_isa_pkg::word_t    rdata_b,
    input  logic                  we,
    input  cpu_isa_pkg::reg_idx_t waddr,
    input  cpu_isa_pkg::word_t    wdata
);
    import cpu_isa_pkg::*;

    word_t regs [16];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 16; i++) begin
                regs[i] <= '0;
            end
        end else if (we) begin
            regs[waddr] <= wdata;
        end
    end

    // Write-through so a reader three cycles behind sees the new value
    always_comb begin
        rdata_a = (we && waddr == raddr_a) ? wdata : regs[raddr_a];
        rdata_b = (we && waddr == raddr_b) ? wdata : regs[raddr_b];
    end

endmodule

`default_nettype wire

// File: hdl/instr_decode.sv
// Decode stage
`timescale 1ns/1ns
`default_nettype none

module instr_decode (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  instr_valid,  // One-cycle strobe
    input  cpu_isa_pkg::word_t    instr,
    input  cpu_isa_pkg::word_t    instr_pc,
    output cpu_isa_pkg::reg_idx_t rs_addr,
    output cpu_isa_pkg::reg_idx_t rt_addr,
    input  cpu_isa_pkg::word_t    rs_data,
    input  cpu_isa_pkg::word_t    rt_data,
    output logic                  d_valid,
    output cpu_ctrl_pkg::alu_op_t d_alu_op,
    output cpu_ctrl_pkg::mem_op_t d_mem_op,
    output cpu_isa_pkg::word_t    d_op_a,
    output cpu_isa_pkg::word_t    d_op_b,
    output cpu_isa_pkg::word_t    d_store_data,
    output cpu_isa_pkg::reg_idx_t d_rd,
    output logic                  d_reg_write,
    output logic                  d_halt
);
    import cpu_isa_pkg::*;
    import cpu_ctrl_pkg::*;

    opcode_t  opcode;
    word_t    imm4_sx;      // Sign-extended rt field
    word_t    imm8_sx;      // Sign-extended low byte
    logic     stopped;      // Set by HLT, held until reset
    logic     accept;
    alu_op_t  alu_op;
    mem_op_t  mem_op;
    word_t    op_b;
    word_t    store_data;
    reg_idx_t rd;
    logic     reg_write;

    assign opcode  = opcode_t'(instr[OPC_MSB:OPC_LSB]);
    assign imm4_sx = {{12{instr[RT_MSB]}}, instr[RT_MSB:RT_LSB]};
    assign imm8_sx = {{8{instr[7]}}, instr[7:0]};
    assign accept  = instr_valid && !stopped;

    // SW reads its store data through the rt port; CALL/RET read sp
    assign rs_addr = (opcode == OP_CALL || opcode == OP_RET) ? SP_REG : instr[RS_MSB:RS_LSB];
    assign rt_addr = (opcode == OP_SW) ? instr[RD_MSB:RD_LSB] : instr[RT_MSB:RT_LSB];

    ////////////////////////////////////////////////////////////////////////////
    // Control generation
    ////////////////////////////////////////////////////////////////////////////
    always_comb begin
        alu_op     = ALU_ADD;
        mem_op     = MEM_NONE;
        op_b       = rt_data;
        store_data = rt_data;
        rd         = instr[RD_MSB:RD_LSB];
        reg_write  = 1'b0;
        case (opcode)
            OP_ADD:  reg_write = 1'b1;
            OP_SUB: begin
                alu_op    = ALU_SUB;
                reg_write = 1'b1;
            end
            OP_AND: begin
                alu_op    = ALU_AND;
                reg_write = 1'b1;
            end
            OP_XOR: begin
                alu_op    = ALU_XOR;
                reg_write = 1'b1;
            end
            OP_ADDI: begin
                op_b      = imm4_sx;
                reg_write = 1'b1;
            end
            OP_LLB: begin
                alu_op    = ALU_PASS_B;
                op_b      = imm8_sx;
                reg_write = 1'b1;
            end
            OP_LW: begin
                mem_op    = MEM_LOAD;
                op_b      = {imm4_sx[14:0], 1'b0};  // Word offset in bytes
                reg_write = 1'b1;
            end
            OP_SW: begin
                mem_op = MEM_STORE;
                op_b   = {imm4_sx[14:0], 1'b0};
            end
            OP_CALL: begin
                mem_op     = MEM_CALL;
                op_b       = '0;         // sp passes through the ALU
                store_data = instr_pc;   // Memory stage adds 2
                rd         = SP_REG;
                reg_write  = 1'b1;
            end
            OP_RET: begin
                mem_op    = MEM_RET;
                op_b      = '0;
                rd        = SP_REG;
                reg_write = 1'b1;
            end
            default: ;                    // HLT, NOP and spare codes
        endcase
    end

    // Valid and stop flag
    always_ff @(posedge clk) begin
        if (rst) begin
            d_valid <= 1'b0;
            stopped <= 1'b0;
        end else begin
            d_valid <= accept;
            if (accept && opcode == OP_HLT) stopped <= 1'b1;
        end
    end

    // Decode/execute payload
    always_ff @(posedge clk) begin
        d_alu_op     <= alu_op;
        d_mem_op     <= mem_op;
        d_op_a       <= rs_data;
        d_op_b       <= op_b;
        d_store_data <= store_data;
        d_rd         <= rd;
        d_reg_write  <= reg_write;
        d_halt       <= (opcode == OP_HLT);
    end

endmodule

`default_nettype wire

// File: hdl/exec_unit.sv
// Execute stage
`timescale 1ns/1ns
`default_nettype none

module exec_unit (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  d_valid,
    input  cpu_ctrl_pkg::alu_op_t d_alu_op,
    input  cpu_ctrl_pkg::mem_op_t d_mem_op,
    input  cpu_isa_pkg::word_t    d_op_a,
    input  cpu_isa_pkg::word_t    d_op_b,
    input  cpu_isa_pkg::word_t    d_store_data,
    input  cpu_isa_pkg::reg_idx_t d_rd,
    input  logic                  d_reg_write,
    input  logic                  d_halt,
    output logic                  e_valid,
    output cpu_ctrl_pkg::mem_op_t e_mem_op,
    output cpu_isa_pkg::word_t    e_alu_result,  // Data, address or sp
    output cpu_isa_pkg::word_t    e_store_data,
    output cpu_isa_pkg::reg_idx_t e_rd,
    output logic                  e_reg_write,
    output logic                  e_halt
);
    import cpu_isa_pkg::*;
    import cpu_ctrl_pkg::*;

    word_t alu_result;

    ////////////////////////////////////////////////////////////////////////////
    // ALU
    ////////////////////////////////////////////////////////////////////////////
    always_comb begin
        case (d_alu_op)
            ALU_ADD: alu_result = d_op_a + d_op_b;  // Also address and sp
            ALU_SUB: alu_result = d_op_a - d_op_b;
            ALU_AND: alu_result = d_op_a & d_op_b;
            ALU_XOR: alu_result = d_op_a ^ d_op_b;
            default: alu_result = d_op_b;           // LLB
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            e_valid <= 1'b0;
        end else begin
            e_valid <= d_valid;
        end
    end

    // Execute/memory payload, control passes straight through
    always_ff @(posedge clk) begin
        e_mem_op     <= d_mem_op;
        e_alu_result <= alu_result;
        e_store_data <= d_store_data;
        e_rd         <= d_rd;
        e_reg_write  <= d_reg_write;
        e_halt       <= d_halt;
    end

endmodule

`default_nettype wire

// File: hdl/data_memory.sv
// Word data memory
`timescale 1ns/1ns
`default_nettype none

module data_memory #(
    parameter int DMEM_WORDS = 256
) (
    input  logic               clk,
    input  logic               rst,
    input  cpu_isa_pkg::word_t addr,   // Byte address, bit 0 ignored
    input  logic               re,
    input  logic               we,
    input  cpu_isa_pkg::word_t wdata,
    output cpu_isa_pkg::word_t rdata   // Registered read
);
    import cpu_isa_pkg::*;

    localparam int AW = $clog2(DMEM_WORDS);

    word_t          mem [DMEM_WORDS];
    logic  [AW-1:0] idx;

    assign idx = addr[AW:1];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < DMEM_WORDS; i++) begin
                mem[i] <= '0;
            end
            rdata <= '0;
        end else begin
            if (we) mem[idx] <= wdata;
            if (re) rdata <= mem[idx];  // Old data on a same-edge write
        end
    end

endmodule

`default_nettype wire

// File: hdl/mem_unit.sv
// Memory stage with call/return stack handling
`timescale 1ns/1ns
`default_nettype none

module mem_unit #(
    parameter int DMEM_WORDS = 256
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  e_valid,
    input  cpu_ctrl_pkg::mem_op_t e_mem_op,
    input  cpu_isa_pkg::word_t    e_alu_result,
    input  cpu_isa_pkg::word_t    e_store_data,  // pc for CALL
    input  cpu_isa_pkg::reg_idx_t e_rd,
    input  logic                  e_reg_write,
    input  logic                  e_halt,
    output logic                  m_valid,
    output logic                  m_from_mem,
    output cpu_isa_pkg::word_t    m_alu_result,
    output cpu_isa_pkg::reg_idx_t m_rd,
    output logic                  m_reg_write,
    output logic                  m_ret,
    output logic                  m_halt,
    output cpu_isa_pkg::word_t    mem_read_data
);
    import cpu_isa_pkg::*;
    import cpu_ctrl_pkg::*;

    word_t mem_addr;
    word_t mem_wdata;
    word_t result;      // Passed on to write-back
    logic  mem_re;
    logic  mem_we;

    ////////////////////////////////////////////////////////////////////////////
    // Stack pointer adjust
    ////////////////////////////////////////////////////////////////////////////
    always_comb begin
        mem_addr  = e_alu_result;
        mem_wdata = e_store_data;
        result    = e_alu_result;
        case (e_mem_op)
            MEM_CALL: begin
                mem_wdata = e_store_data + 16'd2;  // Return point
                result    = e_alu_result - 16'd2;  // Stack grows down
            end
            MEM_RET: begin
                mem_addr = e_alu_result + 16'd2;   // Top of stack
                result   = e_alu_result + 16'd2;
            end
            default: ;
        endcase
    end

    assign mem_re = e_valid && (e_mem_op == MEM_LOAD || e_mem_op == MEM_RET);
    assign mem_we = e_valid && (e_mem_op == MEM_STORE || e_mem_op == MEM_CALL);

    data_memory #(.DMEM_WORDS(DMEM_WORDS)) dmem0 (
        .clk   (clk),
        .rst   (rst),
        .addr  (mem_addr),
        .re    (mem_re),
        .we    (mem_we),
        .wdata (mem_wdata),
        .rdata (mem_read_data)
    );

    always_ff @(posedge clk) begin
        if (rst) begin
            m_valid <= 1'b0;
        end else begin
            m_valid <= e_valid;
        end
    end

    // Memory/write-back payload, in step with the memory read
    always_ff @(posedge clk) begin
        m_from_mem   <= (e_mem_op == MEM_LOAD);
        m_alu_result <= result;
        m_rd         <= e_rd;
        m_reg_write  <= e_reg_write;
        m_ret        <= (e_mem_op == MEM_RET);
        m_halt       <= e_halt;
    end

endmodule

`default_nettype wire

// File: hdl/write_back.sv
// Write-back and result reporting
`timescale 1ns/1ns
`default_nettype none

module write_back (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  m_valid,
    input  logic                  m_from_mem,
    input  cpu_isa_pkg::word_t    m_alu_result,
    input  cpu_isa_pkg::reg_idx_t m_rd,
    input  logic                  m_reg_write,
    input  logic                  m_ret,
    input  logic                  m_halt,
    input  cpu_isa_pkg::word_t    mem_read_data,
    output logic                  rf_we,
    output cpu_isa_pkg::reg_idx_t rf_waddr,
    output cpu_isa_pkg::word_t    rf_wdata,
    output logic                  wb_en,      // Pulse
    output cpu_isa_pkg::reg_idx_t wb_reg,
    output cpu_isa_pkg::word_t    wb_data,
    output logic                  ret_valid,  // Pulse
    output cpu_isa_pkg::word_t    ret_addr,
    output logic                  halted      // Level until reset
);
    // Register write, lands on the same edge the outputs register
    assign rf_we    = m_valid && m_reg_write;
    assign rf_waddr = m_rd;
    assign rf_wdata = m_from_mem ? mem_read_data : m_alu_result;

    always_ff @(posedge clk) begin
        if (rst) begin
            wb_en     <= 1'b0;
            wb_reg    <= '0;
            wb_data   <= '0;
            ret_valid <= 1'b0;
            ret_addr  <= '0;
            halted    <= 1'b0;
        end else begin
            wb_en     <= rf_we;
            wb_reg    <= rf_waddr;
            wb_data   <= rf_wdata;
            ret_valid <= m_valid && m_ret;
            ret_addr  <= mem_read_data;  // Popped word
            if (m_valid && m_halt) halted <= 1'b1;
        end
    end

endmodule

`default_nettype wire

// File: hdl/cpu_core.sv
// Pipelined integer core
`timescale 1ns/1ns
`default_nettype none

module cpu_core #(
    parameter int DMEM_WORDS = 256
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  instr_valid,
    input  cpu_isa_pkg::word_t    instr,
    input  cpu_isa_pkg::word_t    instr_pc,
    output logic                  wb_en,
    output cpu_isa_pkg::reg_idx_t wb_reg,
    output cpu_isa_pkg::word_t    wb_data,
    output logic                  ret_valid,
    output cpu_isa_pkg::word_t    ret_addr,
    output logic                  halted
);
    import cpu_isa_pkg::*;
    import cpu_ctrl_pkg::*;

    // Register file ports
    reg_idx_t rs_addr, rt_addr, rf_waddr;
    word_t    rs_data, rt_data, rf_wdata;
    logic     rf_we;

    // Decode/execute
    logic     d_valid, d_reg_write, d_halt;
    alu_op_t  d_alu_op;
    mem_op_t  d_mem_op;
    word_t    d_op_a, d_op_b, d_store_data;
    reg_idx_t d_rd;

    // Execute/memory
    logic     e_valid, e_reg_write, e_halt;
    mem_op_t  e_mem_op;
    word_t    e_alu_result, e_store_data;
    reg_idx_t e_rd;

    // Memory/write-back
    logic     m_valid, m_from_mem, m_reg_write, m_ret, m_halt;
    word_t    m_alu_result, mem_read_data;
    reg_idx_t m_rd;

    ////////////////////////////////////////////////////////////////////////////
    // Stages
    ////////////////////////////////////////////////////////////////////////////
    instr_decode decode0 (
        .clk, .rst, .instr_valid, .instr, .instr_pc,
        .rs_addr, .rt_addr, .rs_data, .rt_data,
        .d_valid, .d_alu_op, .d_mem_op, .d_op_a, .d_op_b,
        .d_store_data, .d_rd, .d_reg_write, .d_halt
    );

    reg_file rf0 (
        .clk, .rst,
        .raddr_a (rs_addr),
        .raddr_b (rt_addr),
        .rdata_a (rs_data),
        .rdata_b (rt_data),
        .we      (rf_we),
        .waddr   (rf_waddr),
        .wdata   (rf_wdata)
    );

    exec_unit exec0 (
        .clk, .rst,
        .d_valid, .d_alu_op, .d_mem_op, .d_op_a, .d_op_b,
        .d_store_data, .d_rd, .d_reg_write, .d_halt,
        .e_valid, .e_mem_op, .e_alu_result, .e_store_data,
        .e_rd, .e_reg_write, .e_halt
    );

    mem_unit #(.DMEM_WORDS(DMEM_WORDS)) mem0 (
        .clk, .rst,
        .e_valid, .e_mem_op, .e_alu_result, .e_store_data,
        .e_rd, .e_reg_write, .e_halt,
        .m_valid, .m_from_mem, .m_alu_result, .m_rd,
        .m_reg_write, .m_ret, .m_halt, .mem_read_data
    );

    write_back wb0 (
        .clk, .rst,
        .m_valid, .m_from_mem, .m_alu_result, .m_rd,
        .m_reg_write, .m_ret, .m_halt, .mem_read_data,
        .rf_we, .rf_waddr, .rf_wdata,
        .wb_en, .wb_reg, .wb_data, .ret_valid, .ret_addr, .halted
    );

endmodule

`default_nettype wire

// File: testbench/tb_cpu_core.sv
// Pipelined core testbench
`timescale 1ns/1ns
`default_nettype none

module tb_cpu_core;
    import cpu_isa_pkg::*;

    localparam int DMEM_WORDS = 256;
    localparam int OUT_DELAY  = 5;      // Drive edge to negedge after the result edge
    localparam int PC_BASE    = 16'h0100;

    logic     clk;
    logic     rst;
    logic     instr_valid;
    word_t    instr;
    word_t    instr_pc;
    logic     wb_en;
    reg_idx_t wb_reg;
    word_t    wb_data;
    logic     ret_valid;
    word_t    ret_addr;
    logic     halted;

    // Stimulus table
    word_t    row_instr[$];
    int       row_gap[$];               // Cycles to next row (1 is back to back)

    // Reference model
    word_t    model_regs [16];
    word_t    model_mem  [DMEM_WORDS];
    logic     model_stopped;

    // Expected events, oldest first
    reg_idx_t exp_wb_reg[$];
    word_t    exp_wb_data[$];
    int       exp_wb_cyc[$];
    word_t    exp_ret_addr[$];
    int       exp_ret_cyc[$];
    int       exp_halt_cyc;             // Negative until HLT issued
    logic     halt_seen;

    int       cyc = 0;                  // Rising edges since time zero
    int       cycle_limit = 1000;

    cpu_core #(.DMEM_WORDS(DMEM_WORDS)) dut0 (
        .clk         (clk),
        .rst         (rst),
        .instr_valid (instr_valid),
        .instr       (instr),
        .instr_pc    (instr_pc),
        .wb_en       (wb_en),
        .wb_reg      (wb_reg),
        .wb_data     (wb_data),
        .ret_valid   (ret_valid),
        .ret_addr    (ret_addr),
        .halted      (halted)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) cyc <= cyc + 1;

    ////////////////////////////////////////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////////////////////////////////////////
    function automatic word_t encode(input opcode_t op, input reg_idx_t rd,
                                     input reg_idx_t rs, input logic [3:0] rt);
        return {op, rd, rs, rt};
    endfunction

    function automatic word_t encode_llb(input reg_idx_t rd, input logic [7:0] imm);
        return {OP_LLB, rd, imm};
    endfunction

    function automatic int word_index(input word_t addr);
        return int'(addr[15:1]) % DMEM_WORDS;  // Bit 0 ignored
    endfunction

    task automatic add_row(input word_t ins, input int gap);
        row_instr.push_back(ins);
        row_gap.push_back(gap);
    endtask

    task automatic stop_run(input string line);
        $display("%s", line);
        $display("CHECKS FAILED");
        $fatal(1, "run stopped at first failure");
    endtask

    // Register write in the model plus its expected pulse
    task automatic record_write(input reg_idx_t rd, input word_t val, input int out_cyc);
        model_regs[rd] = val;
        exp_wb_reg.push_back(rd);
        exp_wb_data.push_back(val);
        exp_wb_cyc.push_back(out_cyc);
    endtask

    task automatic apply_model(input word_t ins, input word_t pc, input int issue_cyc);
        opcode_t  op;
        reg_idx_t rd;
        reg_idx_t rs;
        reg_idx_t rt;
        word_t    imm4;
        word_t    imm8;
        word_t    addr;
        int       out_cyc;
        if (model_stopped) return;               // Decode ignores all after HLT
        op      = opcode_t'(ins[15:12]);
        rd      = ins[11:8];
        rs      = ins[7:4];
        rt      = ins[3:0];
        imm4    = {{12{ins[3]}}, ins[3:0]};
        imm8    = {{8{ins[7]}}, ins[7:0]};
        addr    = model_regs[rs] + (imm4 << 1);  // Offset counts words
        out_cyc = issue_cyc + OUT_DELAY;
        case (op)
            OP_ADD:  record_write(rd, model_regs[rs] + model_regs[rt], out_cyc);
            OP_SUB:  record_write(rd, model_regs[rs] - model_regs[rt], out_cyc);
            OP_AND:  record_write(rd, model_regs[rs] & model_regs[rt], out_cyc);
            OP_XOR:  record_write(rd, model_regs[rs] ^ model_regs[rt], out_cyc);
            OP_ADDI: record_write(rd, model_regs[rs] + imm4, out_cyc);
            OP_LLB:  record_write(rd, imm8, out_cyc);
            OP_LW:   record_write(rd, model_mem[word_index(addr)], out_cyc);
            OP_SW:   model_mem[word_index(addr)] = model_regs[rd];
            OP_CALL: begin
                addr = model_regs[SP_REG];
                model_mem[word_index(addr)] = pc + 16'd2;   // Return point
                record_write(SP_REG, addr - 16'd2, out_cyc);
            end
            OP_RET: begin
                addr = model_regs[SP_REG] + 16'd2;          // Top of stack
                exp_ret_addr.push_back(model_mem[word_index(addr)]);
                exp_ret_cyc.push_back(out_cyc);
                record_write(SP_REG, addr, out_cyc);
            end
            OP_HLT: begin
                model_stopped = 1'b1;
                exp_halt_cyc  = out_cyc;
            end
            default: ;                                      // NOP
        endcase
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Compare tasks
    ////////////////////////////////////////////////////////////////////////////
    task automatic check_wb(input reg_idx_t exp_reg, input word_t exp_data, input int exp_cyc);
        if (wb_reg !== exp_reg || wb_data !== exp_data || cyc != exp_cyc)
            stop_run($sformatf(
                "error at %0t ns: wb r%0d=%h cycle %0d, expected r%0d=%h cycle %0d",
                $time, wb_reg, wb_data, cyc, exp_reg, exp_data, exp_cyc));
    endtask

    task automatic check_ret(input word_t exp_addr, input int exp_cyc);
        if (ret_addr !== exp_addr || cyc != exp_cyc)
            stop_run($sformatf(
                "error at %0t ns: return %h in cycle %0d, expected %h in cycle %0d",
                $time, ret_addr, cyc, exp_addr, exp_cyc));
    endtask

    task automatic check_halt(input int exp_cyc);
        if (exp_cyc < 0)
            stop_run($sformatf("halted went high at %0t ns with no HLT issued", $time));
        else if (cyc != exp_cyc)
            stop_run($sformatf("error at %0t ns: halted rose in cycle %0d, expected cycle %0d",
                               $time, cyc, exp_cyc));
    endtask

    // Outputs sampled mid-cycle away from the driving edge
    always @(negedge clk) begin
        if (!rst) begin
            if (cyc > cycle_limit) begin
                stop_run($sformatf("timeout after %0d cycles with results still missing", cyc));
            end else begin
                if (wb_en) begin
                    if (exp_wb_reg.size() == 0)
                        stop_run($sformatf("unexpected write-back to r%0d at %0t ns",
                                           wb_reg, $time));
                    else
                        check_wb(exp_wb_reg.pop_front(), exp_wb_data.pop_front(),
                                 exp_wb_cyc.pop_front());
                end
                if (ret_valid) begin
                    if (exp_ret_addr.size() == 0)
                        stop_run($sformatf("unexpected return pulse at %0t ns", $time));
                    else
                        check_ret(exp_ret_addr.pop_front(), exp_ret_cyc.pop_front());
                end
                if (halted && !halt_seen) begin
                    check_halt(exp_halt_cyc);
                    halt_seen = 1'b1;
                end
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Stimulus table
    ////////////////////////////////////////////////////////////////////////////
    task automatic build_table();
        add_row(encode_llb(4'd1, 8'h25), 4);
        add_row(encode_llb(4'd2, 8'h9C), 4);            // Negative byte
        add_row(encode_llb(SP_REG, 8'h40), 4);          // Stack at 0x40
        add_row(encode(OP_ADD,  4'd3, 4'd1, 4'd2), 4);
        add_row(encode(OP_SUB,  4'd4, 4'd1, 4'd2), 4);
        add_row(encode(OP_AND,  4'd5, 4'd1, 4'd2), 4);
        add_row(encode(OP_XOR,  4'd6, 4'd1, 4'd2), 4);
        add_row(encode(OP_ADDI, 4'd7, 4'd1, 4'hD), 4);  // Minus 3
        add_row(encode(OP_ADDI, 4'd8, 4'd2, 4'h7), 4);
        add_row(encode_llb(4'd9, 8'h20), 4);            // Base address
        add_row(encode(OP_SW,   4'd3, 4'd9, 4'h2), 4);
        add_row(encode(OP_SW,   4'd4, 4'd9, 4'hE), 4);  // Offset -2
        add_row(encode(OP_LW,  4'd10, 4'd9, 4'h2), 4);
        add_row(encode(OP_LW,  4'd11, 4'd9, 4'hE), 4);
        add_row(encode(OP_CALL, 4'd0, 4'd0, 4'h0), 4);
        add_row(encode(OP_LW,  4'd12, SP_REG, 4'h1), 4); // Old stack slot
        add_row(encode(OP_CALL, 4'd0, 4'd0, 4'h0), 4);  // Nested
        add_row(encode(OP_RET,  4'd0, 4'd0, 4'h0), 4);
        add_row(encode(OP_RET,  4'd0, 4'd0, 4'h0), 4);
        // Burst of one per cycle
        add_row(encode_llb(4'd1, 8'h11), 1);
        add_row(encode_llb(4'd2, 8'h7F), 1);
        add_row(encode(OP_ADD, 4'd13, 4'd3, 4'd4), 1);
        add_row(encode(OP_XOR, 4'd14, 4'd5, 4'd1), 1);  // r1 on rt exactly 3 cycles on
        add_row(encode(OP_ADDI, 4'd0, 4'd2, 4'h1), 4);  // r2 on rs exactly 3 cycles on
        add_row(encode(OP_NOP,  4'd0, 4'd0, 4'h0), 4);
        // Halt, then two that must be dropped
        add_row(encode(OP_HLT,  4'd0, 4'd0, 4'h0), 1);
        add_row(encode_llb(4'd1, 8'h55), 1);
        add_row(encode(OP_ADD,  4'd2, 4'd1, 4'd1), 4);
    endtask

    initial begin
        int    extra;
        word_t pc;
        rst         = 1'b1;
        instr_valid = 1'b0;
        instr       = '0;
        instr_pc    = '0;
        void'($urandom(46));
        foreach (model_regs[i]) model_regs[i] = '0;
        foreach (model_mem[i]) model_mem[i] = '0;
        model_stopped = 1'b0;
        exp_halt_cyc  = -1;
        halt_seen     = 1'b0;
        build_table();
        cycle_limit = row_instr.size() * 8 + 40;

        repeat (8) @(posedge clk);
        rst <= 1'b0;

        for (int i = 0; i < row_instr.size(); i++) begin
            @(posedge clk);
            pc = 16'(PC_BASE + 2 * i);
            instr_valid <= 1'b1;
            instr       <= row_instr[i];
            instr_pc    <= pc;
            apply_model(row_instr[i], pc, cyc);
            extra = (row_gap[i] > 1) ? int'($urandom % 4) : 0;   // Up to 3 spare cycles
            repeat (row_gap[i] - 1 + extra) begin
                @(posedge clk);
                instr_valid <= 1'b0;
            end
        end
        @(posedge clk);
        instr_valid <= 1'b0;

        // Drain the pipe, then watch for stray pulses
        while (exp_wb_reg.size() > 0 || exp_ret_addr.size() > 0 ||
               (exp_halt_cyc >= 0 && !halt_seen))
            @(negedge clk);
        repeat (8) @(negedge clk);
        if (halted !== 1'b1) begin
            stop_run("halted is not held high at the end of the run");
        end else begin
            $display("ALL CHECKS PASSED");
            $finish;
        end
    end

endmodule

`default_nettype wire

// File: all.f
hdl/cpu_isa_pkg.sv
hdl/cpu_ctrl_pkg.sv
hdl/reg_file.sv
hdl/instr_decode.sv
hdl/exec_unit.sv
hdl/data_memory.sv
hdl/mem_unit.sv
hdl/write_back.sv
hdl/cpu_core.sv
testbench/tb_cpu_core.sv
